/* design/zx_glue_cfg.svh */
`ifndef ZX_GLUE_CFG_SVH
`define ZX_GLUE_CFG_SVH

// low address byte of the ULA port
`define ZX_PORT_FE 8'hFE

// low address byte of the stereo sound chip
`define ZX_PORT_SAA 8'hFF

// bit positions inside the #FE value
`define ZX_FE_TAPE_BIT 3
`define ZX_FE_BEEP_BIT 4

// 28 MHz / 16 gives the 1.75 MHz PSG clock
`define ZX_PSG_DIV 16

// longest INT pulse in clocks
`define ZX_INT_HOLD 32

// IM2 vectors per source
`define ZX_VECT_FRAME 8'hFF
`define ZX_VECT_LINE 8'hFD

`endif

/* design/zx_glue_pkg.sv */
`default_nettype none

package zx_glue_pkg;

  // cpu address
  typedef logic [15:0] addr_t;

  // cpu data byte
  typedef logic [7:0] data_t;

  // border colour from port #FE
  typedef logic [2:0] border_t;

  // IM2 vector byte
  typedef logic [7:0] vect_t;

  // bit 0 enables frame int, bit 1 enables line int
  typedef logic [1:0] int_mask_t;

  // INT request state
  typedef enum logic {
    INT_IDLE,
    INT_ACTIVE
  } int_state_e;

endpackage

`default_nettype wire

/* design/z80_bus_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface z80_bus_if;
  import zx_glue_pkg::*;

  addr_t a;
  data_t dout;
  logic mreq_n;
  logic iorq_n;
  logic rd_n;
  logic wr_n;
  logic m1_n;

  // every glue block only watches the bus
  modport glue (
    input a,
    input dout,
    input mreq_n,
    input iorq_n,
    input rd_n,
    input wr_n,
    input m1_n
  );

endinterface

`default_nettype wire

/* design/sound_ports.sv */
`timescale 1ns/100ps
`default_nettype none

`include "zx_glue_cfg.svh"

module sound_ports (
  input wire clk_28mhz,
  input wire rst,
  z80_bus_if.glue bus,
  output zx_glue_pkg::border_t border,
  output logic tape_out,
  output logic beep,
  output logic ts_sel,
  output logic ts_bdir,
  output logic ts_bc1,
  output logic saa_wr_n,
  output logic saa_a0,
  output logic psg_ce
);
  import zx_glue_pkg::*;

  localparam int PSG_W = $clog2(`ZX_PSG_DIV);

  logic io_wr;
  logic fe_wr;
  data_t fe_q;
  logic [PSG_W-1:0] psg_cnt;
  logic psg_last;

  // no wait states, any cycle with iorq and wr low counts
  assign io_wr = !bus.iorq_n && !bus.wr_n;
  assign fe_wr = io_wr && (bus.a[7:0] == `ZX_PORT_FE);

  // port #FE
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      fe_q <= '0;
    end else if (fe_wr) begin
      fe_q <= bus.dout;
    end
  end

  assign border = fe_q[$bits(border_t)-1:0];
  assign tape_out = fe_q[`ZX_FE_TAPE_BIT];
  assign beep = fe_q[`ZX_FE_BEEP_BIT];

  // twin PSG sits on a15=1, a1=0, a0=1 (#FFFD / #BFFD)
  assign ts_sel = !bus.iorq_n && bus.a[0] && !bus.a[1] && bus.a[15];
  assign ts_bdir = ts_sel && !bus.wr_n;
  assign ts_bc1 = bus.a[14];

  // SAA1099 strobe, register/data chosen by a8
  assign saa_wr_n = !(io_wr && (bus.a[7:0] == `ZX_PORT_SAA));
  assign saa_a0 = bus.a[8];

  // free running divider for the PSG enable
  assign psg_last = (psg_cnt == PSG_W'(`ZX_PSG_DIV - 1));

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      psg_cnt <= '0;
      psg_ce <= 1'b0;
    end else begin
      if (psg_last) begin
        psg_cnt <= '0;
      end else begin
        psg_cnt <= psg_cnt + 1'b1;
      end
      psg_ce <= psg_last;
    end
  end

  // the enable is a single clock wide pulse
  a_psg_ce_single : assert property (
    @(posedge clk_28mhz) disable iff (rst)
    psg_ce |=> !psg_ce
  );

endmodule

`default_nettype wire

/* design/int_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "zx_glue_cfg.svh"

module int_ctrl (
  input wire clk_28mhz,
  input wire rst,
  z80_bus_if.glue bus,
  input wire frame_start,
  input wire line_start,
  input wire ftint,
  input wire ft_int_sel,
  input wire zx_glue_pkg::int_mask_t intmask,
  output logic cpu_int_n,
  output logic intack,
  output zx_glue_pkg::vect_t im2vect
);
  import zx_glue_pkg::*;

  localparam int HOLD_W = $clog2(`ZX_INT_HOLD);

  // [1:0] synchronizer, [2] edge history
  logic [2:0] ft_sr;
  logic ft_fall;
  logic line_ev;
  logic frm_go;
  logic lin_go;
  logic hold_done;
  int_state_e state;
  logic [HOLD_W-1:0] hold_cnt;

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      ft_sr <= '1;
    end else begin
      ft_sr <= {ft_sr[1:0], ftint};
    end
  end

  assign ft_fall = ft_sr[2] && !ft_sr[1];

  // external graphics chip replaces the internal line pulse
  assign line_ev = ft_int_sel ? ft_fall : line_start;

  assign frm_go = frame_start && intmask[0];
  assign lin_go = line_ev && intmask[1];

  // Z80 acknowledges with m1 and iorq together
  assign intack = !bus.m1_n && !bus.iorq_n;

  assign hold_done = (hold_cnt == HOLD_W'(`ZX_INT_HOLD - 1));

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      state <= INT_IDLE;
      hold_cnt <= '0;
      im2vect <= `ZX_VECT_FRAME;
    end else begin
      unique case (state)
        INT_IDLE: begin
          hold_cnt <= '0;
          if (frm_go || lin_go) begin
            state <= INT_ACTIVE;
            // frame wins a tie
            im2vect <= frm_go ? `ZX_VECT_FRAME : `ZX_VECT_LINE;
          end
        end
        INT_ACTIVE: begin
          // new starts are dropped here
          hold_cnt <= hold_cnt + 1'b1;
          if (intack || hold_done) begin
            state <= INT_IDLE;
          end
        end
        default: begin
          state <= INT_IDLE;
        end
      endcase
    end
  end

  assign cpu_int_n = (state != INT_ACTIVE);

  a_int_max_len : assert property (
    @(posedge clk_28mhz) disable iff (rst)
    $fell(cpu_int_n) |-> ##[1:`ZX_INT_HOLD] cpu_int_n
  );

  a_int_ack_release : assert property (
    @(posedge clk_28mhz) disable iff (rst)
    (!cpu_int_n && intack) |=> cpu_int_n
  );

endmodule

`default_nettype wire

/* design/read_mux.sv */
`timescale 1ns/100ps
`default_nettype none

module read_mux (
  input wire clk_28mhz,
  input wire rst,
  z80_bus_if.glue bus,
  input wire csrom,
  input wire zx_glue_pkg::data_t rom_do,
  input wire ram_ena,
  input wire zx_glue_pkg::data_t ram_do,
  input wire ts_sel,
  input wire zx_glue_pkg::data_t ts_do,
  input wire zifi_oe_n,
  input wire zx_glue_pkg::data_t zifi_do,
  input wire fdc_oe,
  input wire zx_glue_pkg::data_t fdc_do,
  input wire ports_ena,
  input wire zx_glue_pkg::data_t ports_do,
  input wire intack,
  input wire zx_glue_pkg::vect_t im2vect,
  output zx_glue_pkg::data_t cpu_di
);

  // first hit wins, empty bus reads as FF
  always_comb begin
    if (csrom && !bus.mreq_n && !bus.rd_n) begin
      cpu_di = rom_do;
    end else if (ram_ena) begin
      cpu_di = ram_do;
    end else if (ts_sel && !bus.rd_n) begin
      cpu_di = ts_do;
    end else if (!zifi_oe_n) begin
      cpu_di = zifi_do;
    end else if (fdc_oe) begin
      cpu_di = fdc_do;
    end else if (ports_ena) begin
      cpu_di = ports_do;
    end else if (intack) begin
      cpu_di = im2vect;
    end else begin
      cpu_di = '1;
    end
  end

  // a floating source would show up as X on the cpu
  a_cpu_di_known : assert property (
    @(posedge clk_28mhz) disable iff (rst)
    !$isunknown(cpu_di)
  );

endmodule

`default_nettype wire

/* design/zx_glue.sv */
`timescale 1ns/100ps
`default_nettype none

module zx_glue (
  input wire clk_28mhz,
  input wire rst,
  input wire zx_glue_pkg::addr_t cpu_a,
  input wire zx_glue_pkg::data_t cpu_do,
  input wire cpu_mreq_n,
  input wire cpu_iorq_n,
  input wire cpu_rd_n,
  input wire cpu_wr_n,
  input wire cpu_m1_n,
  input wire csrom,
  input wire zx_glue_pkg::data_t rom_do,
  input wire ram_ena,
  input wire zx_glue_pkg::data_t ram_do,
  input wire zx_glue_pkg::data_t ts_do,
  input wire zifi_oe_n,
  input wire zx_glue_pkg::data_t zifi_do,
  input wire fdc_oe,
  input wire zx_glue_pkg::data_t fdc_do,
  input wire ports_ena,
  input wire zx_glue_pkg::data_t ports_do,
  input wire frame_start,
  input wire line_start,
  input wire ftint,
  input wire ft_int_sel,
  input wire zx_glue_pkg::int_mask_t intmask,
  output zx_glue_pkg::data_t cpu_di,
  output logic cpu_int_n,
  output zx_glue_pkg::border_t border,
  output logic tape_out,
  output logic beep,
  output logic ts_bdir,
  output logic ts_bc1,
  output logic saa_wr_n,
  output logic saa_a0,
  output logic psg_ce
);
  import zx_glue_pkg::*;

  logic ts_sel;
  logic intack;
  vect_t im2vect;

  z80_bus_if bus ();

  assign bus.a = cpu_a;
  assign bus.dout = cpu_do;
  assign bus.mreq_n = cpu_mreq_n;
  assign bus.iorq_n = cpu_iorq_n;
  assign bus.rd_n = cpu_rd_n;
  assign bus.wr_n = cpu_wr_n;
  assign bus.m1_n = cpu_m1_n;

  sound_ports u_sound_ports (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .bus       (bus),
    .border    (border),
    .tape_out  (tape_out),
    .beep      (beep),
    .ts_sel    (ts_sel),
    .ts_bdir   (ts_bdir),
    .ts_bc1    (ts_bc1),
    .saa_wr_n  (saa_wr_n),
    .saa_a0    (saa_a0),
    .psg_ce    (psg_ce)
  );

  int_ctrl u_int_ctrl (
    .clk_28mhz   (clk_28mhz),
    .rst         (rst),
    .bus         (bus),
    .frame_start (frame_start),
    .line_start  (line_start),
    .ftint       (ftint),
    .ft_int_sel  (ft_int_sel),
    .intmask     (intmask),
    .cpu_int_n   (cpu_int_n),
    .intack      (intack),
    .im2vect     (im2vect)
  );

  read_mux u_read_mux (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .bus       (bus),
    .csrom     (csrom),
    .rom_do    (rom_do),
    .ram_ena   (ram_ena),
    .ram_do    (ram_do),
    .ts_sel    (ts_sel),
    .ts_do     (ts_do),
    .zifi_oe_n (zifi_oe_n),
    .zifi_do   (zifi_do),
    .fdc_oe    (fdc_oe),
    .fdc_do    (fdc_do),
    .ports_ena (ports_ena),
    .ports_do  (ports_do),
    .intack    (intack),
    .im2vect   (im2vect),
    .cpu_di    (cpu_di)
  );

endmodule

`default_nettype wire

/* tests/zx_glue_checks.svh */
`ifndef ZX_GLUE_CHECKS_SVH
`define ZX_GLUE_CHECKS_SVH

// twin PSG decode from the bus now driven
function automatic logic ts_select();
  return !cpu_iorq_n && cpu_a[0] && !cpu_a[1] && cpu_a[15];
endfunction

// {beep, tape_out, border} for a #FE value
function automatic logic [4:0] ref_fe_outputs(data_t fe);
  return {fe[`ZX_FE_BEEP_BIT], fe[`ZX_FE_TAPE_BIT], fe[2:0]};
endfunction

// {ts_bdir, ts_bc1, saa_wr_n, saa_a0}
function automatic logic [3:0] ref_sound_strobes();
  logic saa_hit;
  saa_hit = !cpu_iorq_n && !cpu_wr_n && (cpu_a[7:0] == `ZX_PORT_SAA);
  return {ts_select() && !cpu_wr_n, cpu_a[14], !saa_hit, cpu_a[8]};
endfunction

// read data priority, highest first
function automatic data_t ref_read_mux(vect_t vect);
  if (csrom && !cpu_mreq_n && !cpu_rd_n) return rom_do;
  if (ram_ena) return ram_do;
  if (ts_select() && !cpu_rd_n) return ts_do;
  if (!zifi_oe_n) return zifi_do;
  if (fdc_oe) return fdc_do;
  if (ports_ena) return ports_do;
  if (!cpu_m1_n && !cpu_iorq_n) return vect;
  return 8'hFF;
endfunction

task automatic report_mismatch(string name, string exp, string act);
  $display("FAILED %s: expected %s, actual %s", name, exp, act);
  $display("Result: FAILED");
  $fatal(1, "stopping at the first mismatch");
endtask

task automatic check_data(string name, data_t exp, data_t act);
  if (act !== exp) begin
    report_mismatch(name, $sformatf("8'h%h", exp), $sformatf("8'h%h", act));
  end
endtask

task automatic check_border(string name, border_t exp, border_t act);
  if (act !== exp) begin
    report_mismatch(name, $sformatf("3'b%b", exp), $sformatf("3'b%b", act));
  end
endtask

task automatic check_bit(string name, logic exp, logic act);
  if (act !== exp) begin
    report_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
  end
endtask

task automatic check_vect(string name, vect_t exp, vect_t act);
  if (act !== exp) begin
    report_mismatch(name, $sformatf("8'h%h", exp), $sformatf("8'h%h", act));
  end
endtask

`endif

/* tests/tb_zx_glue.sv */
`timescale 1ns/100ps
`default_nettype none

`include "zx_glue_cfg.svh"

module tb_zx_glue;
  import zx_glue_pkg::*;

  localparam int RAND_CYCLES = 400;
  localparam int PSG_CYCLES = 200;
  // reset, random phase, psg window, interrupt sequences, then slack
  localparam int WATCHDOG_CYCLES = 8 + RAND_CYCLES + PSG_CYCLES + 250;

  logic clk_28mhz;
  logic rst;
  addr_t cpu_a;
  data_t cpu_do, cpu_di, rom_do, ram_do, ts_do, zifi_do, fdc_do, ports_do;
  logic cpu_mreq_n, cpu_iorq_n, cpu_rd_n, cpu_wr_n, cpu_m1_n, cpu_int_n;
  logic csrom, ram_ena, zifi_oe_n, fdc_oe, ports_ena;
  logic frame_start, line_start, ftint, ft_int_sel;
  int_mask_t intmask;
  border_t border;
  logic tape_out, beep, ts_bdir, ts_bc1, saa_wr_n, saa_a0, psg_ce;

  integer seed = 32'h2914_ed0b;
  logic cmp_en;
  data_t fe_model;
  logic [4:0] fe_exp;
  logic [3:0] strb_exp;

  zx_glue u_zx_glue (.*);

  `include "zx_glue_checks.svh"

  initial begin
    clk_28mhz = 1'b0;
    forever #20 clk_28mhz = ~clk_28mhz;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_28mhz);
    $display("run timed out after %0d clock cycles", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  // outputs read here still hold their pre-edge values
  always @(posedge clk_28mhz) begin
    if (cmp_en) begin
      fe_exp = ref_fe_outputs(fe_model);
      check_border("fe border", fe_exp[2:0], border);
      check_bit("fe tape_out", fe_exp[3], tape_out);
      check_bit("fe beep", fe_exp[4], beep);
      strb_exp = ref_sound_strobes();
      check_bit("ts_bdir", strb_exp[3], ts_bdir);
      check_bit("ts_bc1", strb_exp[2], ts_bc1);
      check_bit("saa_wr_n", strb_exp[1], saa_wr_n);
      check_bit("saa_a0", strb_exp[0], saa_a0);
      check_data("read mux", ref_read_mux(`ZX_VECT_FRAME), cpu_di);
      if (!cpu_iorq_n && !cpu_wr_n && cpu_a[7:0] == `ZX_PORT_FE) begin
        fe_model = cpu_do;
      end
    end
  end

  task automatic idle_inputs();
    cpu_a = '0;
    cpu_do = '0;
    {cpu_mreq_n, cpu_iorq_n, cpu_rd_n, cpu_wr_n, cpu_m1_n} = '1;
    {csrom, ram_ena, fdc_oe, ports_ena, frame_start, line_start} = '0;
    {rom_do, ram_do, ts_do, zifi_do, fdc_do, ports_do} = '0;
    zifi_oe_n = 1'b1;
  endtask

  task automatic pulse_sources(logic frm, logic lin);
    @(negedge clk_28mhz);
    frame_start = frm;
    line_start = lin;
    @(negedge clk_28mhz);
    frame_start = 1'b0;
    line_start = 1'b0;
  endtask

  // request must be pending on entry
  task automatic ack_and_release(string name, vect_t vect);
    check_bit({name, " request"}, 1'b0, cpu_int_n);
    {cpu_m1_n, cpu_iorq_n} = 2'b00;
    @(negedge clk_28mhz);
    check_vect({name, " vector"}, vect, cpu_di);
    check_bit({name, " release"}, 1'b1, cpu_int_n);
    {cpu_m1_n, cpu_iorq_n} = 2'b11;
  endtask

  task automatic expect_quiet(string name, int cycles);
    repeat (cycles) begin
      @(negedge clk_28mhz);
      check_bit(name, 1'b1, cpu_int_n);
    end
  endtask

  initial begin
    logic [31:0] r;
    int cycles;
    int last_ce;
    int pulses;
    rst = 1'b1;
    cmp_en = 1'b0;
    fe_model = '0;
    idle_inputs();
    {ftint, ft_int_sel, intmask} = {1'b1, 1'b0, 2'b00};
    repeat (8) @(posedge clk_28mhz);
    @(negedge clk_28mhz);
    rst = 1'b0;
    cmp_en = 1'b1;

    // random bus traffic with FE and FF ports hit often
    repeat (RAND_CYCLES) begin
      @(negedge clk_28mhz);
      r = $random(seed);
      cpu_a = addr_t'($random(seed));
      case (r[1:0])
        2'd0: cpu_a[7:0] = `ZX_PORT_FE;
        2'd1: cpu_a[7:0] = `ZX_PORT_SAA;
        default: ;
      endcase
      cpu_do = data_t'($random(seed));
      {cpu_mreq_n, cpu_iorq_n, cpu_rd_n, cpu_wr_n} = r[5:2];
      cpu_m1_n = !(r[21] && r[22]);
      {csrom, ram_ena, fdc_oe, ports_ena} = r[9:6] & r[13:10] & r[17:14];
      zifi_oe_n = !(r[18] && r[19] && r[20]);
      {rom_do, ram_do, ts_do} = 24'($random(seed));
      {zifi_do, fdc_do, ports_do} = 24'($random(seed));
    end
    @(negedge clk_28mhz);
    cmp_en = 1'b0;
    idle_inputs();

    last_ce = -1;
    pulses = 0;
    for (int i = 0; i < PSG_CYCLES; i++) begin
      @(negedge clk_28mhz);
      if (psg_ce) begin
        if (last_ce >= 0) begin
          check_data("psg_ce spacing", data_t'(`ZX_PSG_DIV), data_t'(i - last_ce));
        end
        last_ce = i;
        pulses++;
      end
    end
    check_bit("psg_ce pulses seen", 1'b1, pulses >= PSG_CYCLES / 16 - 1);

    intmask = 2'b11;
    pulse_sources(1'b0, 1'b1);
    ack_and_release("line int", `ZX_VECT_LINE);
    pulse_sources(1'b1, 1'b0);
    ack_and_release("frame int", `ZX_VECT_FRAME);
    pulse_sources(1'b1, 1'b1);
    ack_and_release("frame and line together", `ZX_VECT_FRAME);
    intmask = 2'b00;
    pulse_sources(1'b1, 1'b1);
    expect_quiet("masked sources", 4);

    // request times out without an acknowledge
    intmask = 2'b01;
    pulse_sources(1'b1, 1'b0);
    cycles = 0;
    while (!cpu_int_n && cycles < 2 * `ZX_INT_HOLD) begin
      cycles++;
      @(negedge clk_28mhz);
    end
    check_data("int hold length", data_t'(`ZX_INT_HOLD), data_t'(cycles));

    // external pin as line source
    ft_int_sel = 1'b1;
    intmask = 2'b10;
    @(negedge clk_28mhz);
    ftint = 1'b0;
    cycles = 0;
    while (cpu_int_n && cycles < 8) begin
      @(negedge clk_28mhz);
      cycles++;
    end
    check_bit("ftint latency 2 to 3 cycles", 1'b1, cycles >= 2 && cycles <= 3);
    ack_and_release("ftint", `ZX_VECT_LINE);
    pulse_sources(1'b0, 1'b1);
    expect_quiet("line_start with ftint selected", 4);
    ftint = 1'b1;
    expect_quiet("ftint rising edge", 4);
    ft_int_sel = 1'b0;
    ftint = 1'b0;
    expect_quiet("ftint with internal line source", 6);

    @(negedge clk_28mhz);
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* zx_glue.f */
+incdir+design
+incdir+tests
design/zx_glue_pkg.sv
design/z80_bus_if.sv
design/sound_ports.sv
design/int_ctrl.sv
design/read_mux.sv
design/zx_glue.sv
tests/tb_zx_glue.sv
